//--- common/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  localparam int step_count_w = 16;  // Steps per move
  localparam int period_w = 16;      // Step period in clock ticks
  localparam int phase_w = 3;        // Index into the 8-entry coil table

  // One move request sampled on start
  typedef struct packed {
    logic [step_count_w-1:0] steps;
    logic [period_w-1:0]     period;     // At least 2
    logic                    dir;        // 1 forward, 0 reverse
    logic                    half_step;
  } move_cmd_t;

  // H-bridge inputs with a1 in the MSB
  typedef struct packed {
    logic a1;
    logic a2;
    logic b1;
    logic b2;
  } coil_t;

  // Half-step sequence for a bipolar motor
  // Even entries drive both coils, odd entries one coil
  localparam coil_t coil_table [8] = '{
    coil_t'(4'b1010),
    coil_t'(4'b0010),
    coil_t'(4'b0110),
    coil_t'(4'b0100),
    coil_t'(4'b0101),
    coil_t'(4'b0001),
    coil_t'(4'b1001),
    coil_t'(4'b1000)
  };

endpackage

`default_nettype wire

//--- hw/step_timer.sv
`default_nettype none

module step_timer (
  input  logic                             CLK,
  input  logic                             rst_n,
  input  logic                             run_en,
  input  logic [stepper_pkg::period_w-1:0] period,
  output logic                             step_tick
);

  logic [stepper_pkg::period_w-1:0] count;
  logic                             at_end;

  // Last tick of the current step period
  assign at_end = (count == period - stepper_pkg::period_w'(1));

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!run_en) begin
      count <= '0;  // Restart cleanly on the next move
    end else if (at_end) begin
      count <= '0;
    end else begin
      count <= count + stepper_pkg::period_w'(1);
    end
  end

  // One pulse per period while the move runs
  assign step_tick = run_en && at_end;

endmodule

`default_nettype wire

//--- hw/move_fsm.sv
`default_nettype none

module move_fsm (
  input  logic                             CLK,
  input  logic                             rst_n,
  input  stepper_pkg::move_cmd_t           cmd,
  input  logic                             start,
  input  logic                             stop,
  input  logic                             step_tick,
  output logic                             run_en,
  output logic [stepper_pkg::period_w-1:0] period,
  output logic                             advance,
  output logic                             dir,
  output logic                             half_step,
  output logic                             energize,
  output logic                             busy,
  output logic                             done
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_finish
  } state_t;

  state_t                               state;
  stepper_pkg::move_cmd_t               cmd_q;
  logic [stepper_pkg::step_count_w-1:0] remaining;
  logic                                 accept;

  assign accept = (state == st_idle) && start;  // Start while busy falls through

  // Command held for the whole move
  always_ff @(posedge CLK) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  assign period = cmd_q.period;
  assign dir = cmd_q.dir;
  assign half_step = cmd_q.half_step;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= st_idle;
      remaining <= '0;
      run_en <= 1'b0;
      advance <= 1'b0;
      energize <= 1'b0;
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      advance <= 1'b0;
      energize <= 1'b0;
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_run;
            remaining <= cmd.steps;
            run_en <= 1'b1;
            energize <= 1'b1;  // Show the held pattern first
          end
        end
        st_run: begin
          if (stop) begin
            // Abort with the coils left holding
            state <= st_idle;
            run_en <= 1'b0;
            busy <= 1'b0;
          end else begin
            busy <= 1'b1;
            if (remaining == '0) begin
              state <= st_finish;
              run_en <= 1'b0;
            end else if (step_tick) begin
              remaining <= remaining - stepper_pkg::step_count_w'(1);
              advance <= 1'b1;
            end
          end
        end
        st_finish: begin
          state <= st_idle;
          busy <= 1'b0;
          done <= !stop;  // A late stop still suppresses done
        end
        default: begin
          state <= st_idle;
          run_en <= 1'b0;
          busy <= 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- stepper/phase_sequencer.sv
`default_nettype none

module phase_sequencer (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                advance,
  input  logic                dir,
  input  logic                half_step,
  input  logic                energize,
  output stepper_pkg::coil_t  coils,
  output logic                pwm_a,
  output logic                pwm_b
);

  logic [stepper_pkg::phase_w-1:0] phase;
  logic [stepper_pkg::phase_w-1:0] delta;
  logic [stepper_pkg::phase_w-1:0] next_phase;
  stepper_pkg::coil_t              cur_pat;
  stepper_pkg::coil_t              next_pat;

  // Full step skips the odd entries
  assign delta = half_step ? stepper_pkg::phase_w'(1) : stepper_pkg::phase_w'(2);

  // Index wraps modulo 8 in both directions
  assign next_phase = dir ? (phase + delta) : (phase - delta);

  assign cur_pat = stepper_pkg::coil_table[phase];
  assign next_pat = stepper_pkg::coil_table[next_phase];

  // Position is kept across moves
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (advance) begin
      phase <= next_phase;
    end
  end

  // Bridge outputs
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      coils <= '0;  // Motor unpowered until the first move
      pwm_a <= 1'b0;
      pwm_b <= 1'b0;
    end else if (energize) begin
      coils <= cur_pat;
      pwm_a <= cur_pat.a1 | cur_pat.a2;
      pwm_b <= cur_pat.b1 | cur_pat.b2;
    end else if (advance) begin
      coils <= next_pat;
      pwm_a <= next_pat.a1 | next_pat.a2;
      pwm_b <= next_pat.b1 | next_pat.b2;
    end
    // Otherwise hold for holding torque
  end

endmodule

`default_nettype wire

//--- hw/stepper_ctrl.sv
`default_nettype none

module stepper_ctrl (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  stepper_pkg::move_cmd_t cmd,
  input  logic                   start,
  input  logic                   stop,
  output stepper_pkg::coil_t     coils,
  output logic                   pwm_a,
  output logic                   pwm_b,
  output logic                   busy,
  output logic                   done
);

  logic                             run_en;
  logic [stepper_pkg::period_w-1:0] period;
  logic                             step_tick;
  logic                             advance;
  logic                             dir;
  logic                             half_step;
  logic                             energize;

  // Step pacing
  step_timer u_step_timer (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .run_en    (run_en),
    .period    (period),
    .step_tick (step_tick)
  );

  move_fsm u_move_fsm (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .start     (start),
    .stop      (stop),
    .step_tick (step_tick),
    .run_en    (run_en),
    .period    (period),
    .advance   (advance),
    .dir       (dir),
    .half_step (half_step),
    .energize  (energize),
    .busy      (busy),
    .done      (done)
  );

  // Coil drive
  phase_sequencer u_phase_sequencer (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .advance   (advance),
    .dir       (dir),
    .half_step (half_step),
    .energize  (energize),
    .coils     (coils),
    .pwm_a     (pwm_a),
    .pwm_b     (pwm_b)
  );

endmodule

`default_nettype wire

//--- test/stepper_tb.sv
`default_nettype none

module stepper_tb;

  logic                   CLK;
  logic                   rst_n;
  stepper_pkg::move_cmd_t cmd;
  logic                   start;
  logic                   stop;
  stepper_pkg::coil_t     coils;
  logic                   pwm_a;
  logic                   pwm_b;
  logic                   busy;
  logic                   done;

  // Eight words per line of test/stepper_trace.txt
  logic [31:0] trace_mem [0:255];

  int          error_count;
  int          check_count;
  int          budget_cycles;
  int          cur_test;
  int          model_phase;  // Reference position kept apart from the DUT
  logic [31:0] rng_state;

  stepper_ctrl dut (
    .CLK   (CLK),
    .rst_n (rst_n),
    .cmd   (cmd),
    .start (start),
    .stop  (stop),
    .coils (coils),
    .pwm_a (pwm_a),
    .pwm_b (pwm_b),
    .busy  (busy),
    .done  (done)
  );

  always #10 CLK = ~CLK;

  // Coil pattern a1 a2 b1 b2 at a table index
  function automatic int pattern_at(input int p);
    case (p)
      0: pattern_at = 'hA;
      1: pattern_at = 'h2;
      2: pattern_at = 'h6;
      3: pattern_at = 'h4;
      4: pattern_at = 'h5;
      5: pattern_at = 'h1;
      6: pattern_at = 'h9;
      default: pattern_at = 'h8;
    endcase
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      error_count++;
      $display("Error: test %0d %s expected %0h actual %0h", cur_test, what, expected,
               actual);
    end
  endtask

  // Bridge enables track the coil bits every cycle
  task automatic check_outputs_consistent();
    check_value("pwm_a", int'(coils.a1 | coils.a2), int'(pwm_a));
    check_value("pwm_b", int'(coils.b1 | coils.b2), int'(pwm_b));
  endtask

  task automatic idle_gap(input int cycles);
    int held;
    held = int'(coils);
    repeat (cycles) begin
      @(posedge CLK);
      @(negedge CLK);
      check_value("idle busy", 0, int'(busy));
      check_value("idle done", 0, int'(done));
      check_value("idle coils held", held, int'(coils));
      check_outputs_consistent();
    end
  endtask

  task automatic run_move(input logic [7:0] base);
    int steps;
    int period;
    int dir;
    int half;
    int stop_at;
    int exp_changes;
    int exp_end;
    int delta;
    int n;
    int changes;
    int dones;
    int done_at;
    int prev;
    int step_phase;
    bit finished;

    cur_test = int'(trace_mem[base]);
    steps = int'(trace_mem[base + 8'd1]);
    period = int'(trace_mem[base + 8'd2]);
    dir = int'(trace_mem[base + 8'd3]);
    half = int'(trace_mem[base + 8'd4]);
    stop_at = int'(trace_mem[base + 8'd5]);

    // A stop at cycle k lets through the steps already ticked before k
    exp_changes = steps;
    if (stop_at != 0 && (stop_at - 1) / period < steps) begin
      exp_changes = (stop_at - 1) / period;
    end
    if (stop_at != 0) begin
      exp_end = stop_at;
    end else if (steps == 0) begin
      exp_end = 2;
    end else begin
      exp_end = steps * period + 2;
    end
    delta = (half != 0) ? 1 : 2;

    @(posedge CLK);
    cmd.steps <= trace_mem[base + 8'd1][15:0];
    cmd.period <= trace_mem[base + 8'd2][15:0];
    cmd.dir <= trace_mem[base + 8'd3][0];
    cmd.half_step <= trace_mem[base + 8'd4][0];
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;  // Accepted at this edge

    n = 0;
    changes = 0;
    dones = 0;
    done_at = 0;
    prev = pattern_at(model_phase);
    step_phase = model_phase;
    finished = 0;
    while (!finished) begin
      @(posedge CLK);
      n++;
      if (n == 1) begin
        // A second start while busy must be ignored
        cmd.steps <= 16'd1;
        cmd.dir <= ~trace_mem[base + 8'd3][0];
        start <= 1'b1;
      end
      if (n == 2) start <= 1'b0;
      if (stop_at != 0 && n == stop_at - 1) stop <= 1'b1;
      if (stop_at != 0 && n == stop_at) stop <= 1'b0;
      @(negedge CLK);
      check_outputs_consistent();
      if (done) begin
        dones++;
        done_at = n;
      end
      if (n == 1) begin
        check_value("busy after start", 1, int'(busy));
        check_value("energized pattern", prev, int'(coils));
      end else if (int'(coils) != prev) begin
        changes++;
        check_value("change cycle", changes * period + 1, n);
        if (dir != 0) begin
          step_phase = (step_phase + delta) % 8;
        end else begin
          step_phase = (step_phase + 8 - delta) % 8;
        end
        check_value("step coils", pattern_at(step_phase), int'(coils));
      end
      prev = int'(coils);
      if (n >= 2 && !busy) begin
        finished = 1;
      end else if (n > exp_end + 4) begin
        error_count++;
        $display("Test %0d: busy stayed high well past the expected end of the move",
                 cur_test);
        finished = 1;
      end
    end

    if (dir != 0) begin
      model_phase = (model_phase + delta * exp_changes) % 8;
    end else begin
      model_phase = ((model_phase - delta * exp_changes) % 8 + 8) % 8;
    end

    check_value("end cycle", exp_end, n);
    check_value("done pulses", (stop_at != 0) ? 0 : 1, dones);
    if (stop_at == 0) begin
      check_value("done cycle", exp_end, done_at);
    end
    check_value("change count", int'(trace_mem[base + 8'd7]), changes);
    check_value("model change count", exp_changes, changes);
    check_value("final coils", int'(trace_mem[base + 8'd6]), int'(coils));
    check_value("model coils", pattern_at(model_phase), int'(coils));
  endtask

  // Watchdog sized from the trace
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge CLK);
    $display("Timeout: the simulation ran out of time waiting for done");
    $display("Checks: %0d, errors: %0d, timeouts: 1", check_count, error_count);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [7:0] base;
    int total;

    CLK = 1'b0;
    rst_n = 1'b0;
    cmd = '0;
    start = 1'b0;
    stop = 1'b0;
    error_count = 0;
    check_count = 0;
    budget_cycles = 0;
    cur_test = 0;
    model_phase = 0;
    rng_state = 32'hef46;

    $readmemh("test/stepper_trace.txt", trace_mem);

    total = 100;
    base = 8'd0;
    while (trace_mem[base] != 32'h0000ffff && base < 8'd248) begin
      total += int'(trace_mem[base + 8'd1]) * int'(trace_mem[base + 8'd2]) + 100;
      base += 8'd8;
    end
    budget_cycles = total;

    // Outputs stay low through reset
    repeat (15) begin
      @(posedge CLK);
      @(negedge CLK);
      check_value("reset coils", 0, int'(coils));
      check_value("reset pwm_a", 0, int'(pwm_a));
      check_value("reset pwm_b", 0, int'(pwm_b));
      check_value("reset busy", 0, int'(busy));
      check_value("reset done", 0, int'(done));
    end
    @(posedge CLK);
    rst_n <= 1'b1;
    idle_gap(4);
    check_value("coils before first move", 0, int'(coils));

    base = 8'd0;
    while (trace_mem[base] != 32'h0000ffff && base < 8'd248) begin
      run_move(base);
      rng_state = xorshift(rng_state);
      idle_gap(int'(rng_state[2:0]) + 2);
      base += 8'd8;
    end

    $display("Checks: %0d, errors: %0d, timeouts: 0", check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
common/stepper_pkg.sv
hw/step_timer.sv
hw/move_fsm.sv
stepper/phase_sequencer.sv
hw/stepper_ctrl.sv
test/stepper_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the stepper controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module stepper_tb -f sim.f -o stepper_sim \
  > build.log 2>&1 &&
  ./obj_dir/stepper_sim > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; echo "Simulation build or run failed"; exit 1; }

grep -q "^RESULT: PASS$" sim.log &&
  echo "Simulation passed" ||
  { cat sim.log; echo "Simulation failed"; exit 1; }

//--- test/stepper_trace.txt
// id steps period dir half_step stop_at, then expected coils and coil changes
// All hex, stop_at 0 means no stop, line ffff ends the trace
01 0004 0003 1 0 00 a 4
02 0003 0002 0 0 00 6 3
03 0005 0004 1 1 00 8 5
04 0003 0003 0 1 00 5 3
05 0000 0005 1 0 00 5 0
06 000a 0004 1 0 0d 6 3
07 0006 0002 1 1 00 a 6
08 0001 0007 0 1 00 8 1
09 0003 0002 1 0 00 1 3
0a 0002 0005 0 0 00 2 2
0b 0008 0003 0 1 0a 9 3
0c 0002 0002 1 1 00 a 2
0d 0000 0002 0 1 00 a 0
0e 0007 0002 1 0 00 9 7
0f 0003 0006 1 1 00 2 3
10 0004 0003 0 0 05 8 1
11 0009 0002 0 1 00 9 9
12 0001 000a 1 0 00 a 1
13 000b 0002 1 1 00 4 b
14 0005 0004 0 0 00 2 5
15 0005 0008 0 1 03 2 0
16 0004 0003 1 1 00 1 4
17 0006 0002 1 0 00 2 6
18 0001 0002 0 1 00 a 1
19 0003 0007 0 0 00 6 3
1a 000d 0002 1 1 00 8 d
1b 0002 0009 1 0 00 4 2
1c 0006 0005 0 1 16 8 4
1d 0008 0002 0 0 00 8 8
1e 0002 0003 1 1 00 2 2
ffff 0000 0000 0 0 00 0 0
